// ==== execute_stage.f ====
+incdir+hw
hw/exec_pkg.sv
hw/alu.sv
hw/reg_hilo.sv
hw/branch_control.sv
hw/execute_stage.sv
verif/execute_stage_sva.sv
verif/execute_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= execute_stage_tb
RTL_TOP   ?= execute_stage
FILELIST  ?= execute_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RTL_SRCS  ?= hw/exec_pkg.sv hw/alu.sv hw/reg_hilo.sv hw/branch_control.sv hw/execute_stage.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

lint:
	$(VERILATOR) --lint-only -Wall +incdir+hw --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/execute_stage_tb.sv ====
`timescale 1ns/1ps
`include "exec_params.svh"

module execute_stage_tb;
    import exec_pkg::*;

    localparam int N_INSTR = 500;
    localparam int MAX_CYCLES = N_INSTR * 40;

    typedef struct {
        word_t     pc;
        word_t     rs;
        word_t     rt;
        word_t     imm;
        logic [4:0] shamt;
        alu_op_t   alu_op;
        logic      src2_is_imm;
        logic      trap_ov;
        hilo_op_t  hop;
        res_sel_t  rsel;
        br_op_t    bop;
        word_t     btgt;
        word_t     jtgt;
        logic      pt;
        word_t     ptgt;
        reg_addr_t dest;
        logic      rf_we;
        logic      ex;
        exccode_t  code;
    } instr_t;

    logic clk = 1'b0;
    logic rst;
    logic flush;
    logic ds_valid;
    logic es_allowin;
    word_t ds_pc;
    word_t ds_rs_value;
    word_t ds_rt_value;
    word_t ds_imm;
    logic [4:0] ds_shamt;
    alu_op_t ds_alu_op;
    logic ds_src2_is_imm;
    logic ds_trap_ov;
    hilo_op_t ds_hi_lo_op;
    res_sel_t ds_res_sel;
    br_op_t ds_br_op;
    word_t ds_branch_target;
    word_t ds_jump_target;
    logic ds_predict_taken;
    word_t ds_predict_target;
    reg_addr_t ds_dest;
    logic ds_rf_we;
    logic ds_ex;
    exccode_t ds_exccode;
    logic pms_allowin;
    logic es_to_valid;
    word_t es_pc;
    word_t es_result;
    reg_addr_t es_dest;
    logic es_rf_we;
    logic es_ex;
    exccode_t es_exccode;
    logic br_valid;
    logic br_taken;
    logic br_predict_ok;
    word_t br_target;
    logic fwd_valid;
    reg_addr_t fwd_dest;
    word_t fwd_result;

    instr_t q[$];
    word_t m_hi = '0;
    word_t m_lo = '0;

    always #2 clk = ~clk;

    execute_stage DUT (.*);

    task automatic fail_msg(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic writes_hilo(input hilo_op_t op);
        return op inside {hilo_mult, hilo_multu, hilo_div, hilo_divu, hilo_mthi, hilo_mtlo};
    endfunction

    function automatic word_t alu_model(input instr_t i);
        word_t b;
        b = i.src2_is_imm ? i.imm : i.rt;
        case (i.alu_op)
            alu_add:  return i.rs + b;
            alu_sub:  return i.rs - b;
            alu_slt:  return ($signed(i.rs) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (i.rs < b) ? 32'd1 : 32'd0;
            alu_and:  return i.rs & b;
            alu_or:   return i.rs | b;
            alu_xor:  return i.rs ^ b;
            alu_nor:  return ~(i.rs | b);
            alu_sll:  return b << i.shamt;
            alu_srl:  return b >> i.shamt;
            alu_sra:  return word_t'($signed(b) >>> i.shamt);
            default:  return {b[15:0], 16'h0};
        endcase
    endfunction

    // overflow from the exact sum in 64 bits
    function automatic logic ov_model(input instr_t i);
        longint a;
        longint b;
        longint s;
        a = longint'($signed(i.rs));
        b = longint'($signed(i.src2_is_imm ? i.imm : i.rt));
        if (i.alu_op == alu_add) begin
            s = a + b;
        end else if (i.alu_op == alu_sub) begin
            s = a - b;
        end else begin
            return 1'b0;
        end
        return i.trap_ov && (s > 64'sd2147483647 || s < -64'sd2147483648);
    endfunction

    // mult and div wait for the HI/LO unit unless they fault
    function automatic logic is_single_cycle(input instr_t i);
        if (i.hop inside {hilo_mult, hilo_multu, hilo_div, hilo_divu}) begin
            return i.ex || ov_model(i);
        end
        return 1'b1;
    endfunction

    function automatic word_t result_model(input instr_t i);
        case (i.rsel)
            res_hilo: return (i.hop == hilo_mfhi) ? m_hi : m_lo;
            res_rt:   return i.rt;
            default:  return alu_model(i);
        endcase
    endfunction

    function automatic logic taken_model(input instr_t i);
        case (i.bop)
            br_beq:  return i.rs == i.rt;
            br_bne:  return i.rs != i.rt;
            br_bgez: return $signed(i.rs) >= 0;
            br_bgtz: return $signed(i.rs) > 0;
            br_blez: return $signed(i.rs) <= 0;
            br_bltz: return $signed(i.rs) < 0;
            br_j:    return 1'b1;
            br_jr:   return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t target_model(input instr_t i);
        if (i.bop == br_jr) begin
            return i.rs;
        end
        return (i.bop == br_j) ? i.jtgt : i.btgt;
    endfunction

    task automatic update_hilo(input instr_t i);
        longint a;
        longint b;
        logic [63:0] p;
        a = longint'($signed(i.rs));
        b = longint'($signed(i.rt));
        case (i.hop)
            hilo_mult: begin
                p = a * b;
                {m_hi, m_lo} = p;
            end
            hilo_multu: begin
                p = {32'h0, i.rs} * {32'h0, i.rt};
                {m_hi, m_lo} = p;
            end
            hilo_div: begin
                if (i.rt != 0) begin
                    m_lo = word_t'(a / b);
                    m_hi = word_t'(a % b);
                end
            end
            hilo_divu: begin
                if (i.rt != 0) begin
                    m_lo = i.rs / i.rt;
                    m_hi = i.rs % i.rt;
                end
            end
            hilo_mthi: m_hi = i.rs;
            hilo_mtlo: m_lo = i.rs;
            default: ;
        endcase
    endtask

    function automatic instr_t capture();
        instr_t i;
        i = '{ds_pc, ds_rs_value, ds_rt_value, ds_imm, ds_shamt, ds_alu_op, ds_src2_is_imm,
              ds_trap_ov, ds_hi_lo_op, ds_res_sel, ds_br_op, ds_branch_target, ds_jump_target,
              ds_predict_taken, ds_predict_target, ds_dest, ds_rf_we, ds_ex, ds_exccode};
        return i;
    endfunction

    // operands near the signed limits overflow often
    function automatic word_t edge_operand();
        return $urandom_range(0, 1) ? 32'h7fff_ff00 + $urandom_range(0, 255)
                                    : 32'h8000_0000 + $urandom_range(0, 255);
    endfunction

    function automatic instr_t make_instr(input word_t pc);
        instr_t i;
        int kind;
        kind = $urandom_range(0, 9);
        i.pc = pc;
        i.rs = $urandom();
        i.rt = $urandom();
        i.imm = $urandom();
        i.shamt = 5'($urandom());
        i.alu_op = alu_op_t'($urandom_range(0, 11));
        i.src2_is_imm = 1'($urandom_range(0, 1));
        i.trap_ov = 1'($urandom_range(0, 1));
        i.hop = hilo_none;
        i.rsel = res_alu;
        i.bop = br_none;
        i.btgt = $urandom();
        i.jtgt = $urandom();
        i.dest = reg_addr_t'($urandom());
        i.rf_we = $urandom_range(0, 7) != 0;
        i.ex = $urandom_range(0, 9) == 0;
        i.code = exccode_t'($urandom());
        if (kind <= 3 && $urandom_range(0, 2) == 0) begin
            i.rs = edge_operand();
            i.rt = edge_operand();
            i.src2_is_imm = 1'b0;
            i.alu_op = $urandom_range(0, 1) ? alu_add : alu_sub;
        end else if (kind == 4 || kind == 5) begin
            i.hop = hilo_op_t'($urandom_range(1, 4));
            if ($urandom_range(0, 5) == 0) begin
                i.rt = '0;
            end
        end else if (kind == 6) begin
            i.hop = $urandom_range(0, 1) ? hilo_mthi : hilo_mtlo;
        end else if (kind == 7) begin
            i.hop = $urandom_range(0, 1) ? hilo_mfhi : hilo_mflo;
            i.rsel = res_hilo;
        end else if (kind == 8) begin
            i.bop = br_op_t'($urandom_range(1, 8));
            if ($urandom_range(0, 1)) begin
                i.rt = i.rs;
            end
        end else if (kind == 9) begin
            i.rsel = res_rt;
        end
        if (i.hop != hilo_none && i.rsel != res_hilo) begin
            i.trap_ov = 1'b0;
            i.rf_we = 1'b0;
        end
        i.pt = 1'($urandom_range(0, 1));
        i.ptgt = $urandom_range(0, 1) ? target_model(i) : $urandom();
        return i;
    endfunction

    task automatic drive_instr(input instr_t i);
        ds_pc             <= i.pc;
        ds_rs_value       <= i.rs;
        ds_rt_value       <= i.rt;
        ds_imm            <= i.imm;
        ds_shamt          <= i.shamt;
        ds_alu_op         <= i.alu_op;
        ds_src2_is_imm    <= i.src2_is_imm;
        ds_trap_ov        <= i.trap_ov;
        ds_hi_lo_op       <= i.hop;
        ds_res_sel        <= i.rsel;
        ds_br_op          <= i.bop;
        ds_branch_target  <= i.btgt;
        ds_jump_target    <= i.jtgt;
        ds_predict_taken  <= i.pt;
        ds_predict_target <= i.ptgt;
        ds_dest           <= i.dest;
        ds_rf_we          <= i.rf_we;
        ds_ex             <= i.ex;
        ds_exccode        <= i.code;
    endtask

    task automatic check_departure();
        instr_t e;
        logic ex;
        if (q.size() == 0) begin
            fail_msg("an instruction left the stage that was never accepted");
        end
        e = q.pop_front();
        ex = e.ex || ov_model(e);
        check_value("es_pc", es_pc, e.pc);
        check_value("es_result", es_result, result_model(e));
        check_value("es_dest", 32'(es_dest), 32'(e.dest));
        check_value("es_ex", 32'(es_ex), 32'(ex));
        check_value("es_exccode", 32'(es_exccode),
                    e.ex ? 32'(e.code) : (ex ? 32'(`EXCCODE_OV) : 32'h0));
        check_value("es_rf_we", 32'(es_rf_we), 32'(e.rf_we && !ex));
        if (!ex) begin
            update_hilo(e);
        end
    endtask

    // scoreboard on the values in effect at each edge
    always @(posedge clk) begin
        if (rst) begin
            q.delete();
        end else begin
            check_value("br_valid", 32'(br_valid), 32'(q.size() != 0));
            if (q.size() != 0) begin
                check_value("br_taken", 32'(br_taken), 32'(taken_model(q[0])));
                check_value("br_target", br_target, target_model(q[0]));
                check_value("br_predict_ok", 32'(br_predict_ok),
                            32'((taken_model(q[0]) == q[0].pt)
                                && (!taken_model(q[0]) || target_model(q[0]) == q[0].ptgt)));
                check_value("fwd_dest", 32'(fwd_dest),
                            (q[0].rf_we && !(q[0].ex || ov_model(q[0]))) ? 32'(q[0].dest) : 0);
                if (is_single_cycle(q[0])) begin
                    check_value("es_to_valid", 32'(es_to_valid), 32'h1);
                    check_value("fwd_valid", 32'(fwd_valid), 32'h1);
                end
                if (fwd_valid) begin
                    check_value("fwd_result", fwd_result, result_model(q[0]));
                end
            end else begin
                check_value("fwd_dest", 32'(fwd_dest), 32'h0);
            end
            if (flush) begin
                q.delete();
            end else begin
                if (es_to_valid && pms_allowin) begin
                    check_departure();
                end
                if (ds_valid && es_allowin) begin
                    q.push_back(capture());
                    if (q.size() > 1) begin
                        fail_msg("stage accepted a second instruction while still full");
                    end
                end
            end
        end
    end

    initial begin
        #(MAX_CYCLES * 4);
        fail_msg("watchdog expired before all instructions left the stage");
    end

    initial begin
        int sent;
        int wait_cycles;
        logic last_writer;
        logic flush_now;
        word_t pc;
        void'($urandom(32'h8648));
        rst = 1'b1;
        flush = 1'b0;
        ds_valid = 1'b0;
        pms_allowin = 1'b1;
        drive_instr(make_instr(32'h0));
        sent = 0;
        pc = 32'h0000_1000;
        last_writer = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        while (sent < N_INSTR) begin
            @(posedge clk);
            flush_now = 1'b0;
            if (ds_valid && es_allowin) begin
                sent++;
                last_writer = writes_hilo(ds_hi_lo_op);
            end
            if (ds_valid && !es_allowin) begin
                // offer held until the stage takes it
            end else if (sent >= N_INSTR) begin
                ds_valid <= 1'b0;
            end else if ($urandom_range(0, 7) == 0) begin
                ds_valid <= 1'b0;
                flush_now = !last_writer && $urandom_range(0, 3) == 0;
            end else begin
                drive_instr(make_instr(pc));
                pc = pc + 4;
                ds_valid <= 1'b1;
            end
            flush <= flush_now;
            pms_allowin <= flush_now ? 1'b0 : ($urandom_range(0, 3) != 0);
        end
        @(posedge clk);
        flush <= 1'b0;
        pms_allowin <= 1'b1;
        wait_cycles = 0;
        while (q.size() != 0 && wait_cycles < 100) begin
            @(posedge clk);
            wait_cycles++;
        end
        repeat (2) @(posedge clk);
        if (q.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            fail_msg("instructions still held at the end of the run");
        end
    end

endmodule

// ==== verif/execute_stage_sva.sv ====
`timescale 1ns/1ps

module execute_stage_sva (
    input logic                clk,
    input logic                rst,
    input logic                flush,
    input logic                ds_valid,
    input exec_pkg::hilo_op_t  ds_hi_lo_op,
    input logic                es_allowin,
    input logic                pms_allowin,
    input logic                es_to_valid,
    input exec_pkg::word_t     es_pc,
    input exec_pkg::word_t     es_result,
    input exec_pkg::reg_addr_t es_dest,
    input logic                es_rf_we,
    input logic                es_ex,
    input exec_pkg::exccode_t  es_exccode,
    input logic                br_valid,
    input logic                fwd_valid
);
    import exec_pkg::*;

    // pipeline empty and open right after reset
    reset_clears: assert property (@(posedge clk)
        rst |=> !es_to_valid && !br_valid && !fwd_valid && es_allowin)
        else $error("stage not empty after reset");

    // stalled result holds until the memory side takes it
    stall_holds: assert property (@(posedge clk) disable iff (rst)
        es_to_valid && !pms_allowin && !flush |=> es_to_valid && $stable(es_pc)
            && $stable(es_result) && $stable(es_dest) && $stable(es_rf_we)
            && $stable(es_ex) && $stable(es_exccode))
        else $error("outputs changed under back-pressure");

    // single-cycle ops are ready one cycle after accept
    alu_one_cycle: assert property (@(posedge clk) disable iff (rst)
        ds_valid && es_allowin && ds_hi_lo_op == hilo_none && !flush |=> es_to_valid)
        else $error("single-cycle instruction not ready after one cycle");

    flush_empties: assert property (@(posedge clk) disable iff (rst)
        flush |=> !es_to_valid && !br_valid)
        else $error("stage still valid after flush");

endmodule

bind execute_stage execute_stage_sva sva_i (.*);

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps
`include "exec_params.svh"

module execute_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                ds_valid,
    output logic                es_allowin,
    input  exec_pkg::word_t     ds_pc,
    input  exec_pkg::word_t     ds_rs_value,
    input  exec_pkg::word_t     ds_rt_value,
    input  exec_pkg::word_t     ds_imm,
    input  logic [4:0]          ds_shamt,
    input  exec_pkg::alu_op_t   ds_alu_op,
    input  logic                ds_src2_is_imm,
    input  logic                ds_trap_ov,
    input  exec_pkg::hilo_op_t  ds_hi_lo_op,
    input  exec_pkg::res_sel_t  ds_res_sel,
    input  exec_pkg::br_op_t    ds_br_op,
    input  exec_pkg::word_t     ds_branch_target,
    input  exec_pkg::word_t     ds_jump_target,
    input  logic                ds_predict_taken,
    input  exec_pkg::word_t     ds_predict_target,
    input  exec_pkg::reg_addr_t ds_dest,
    input  logic                ds_rf_we,
    input  logic                ds_ex,
    input  exec_pkg::exccode_t  ds_exccode,
    input  logic                pms_allowin,
    output logic                es_to_valid,
    output exec_pkg::word_t     es_pc,
    output exec_pkg::word_t     es_result,
    output exec_pkg::reg_addr_t es_dest,
    output logic                es_rf_we,
    output logic                es_ex,
    output exec_pkg::exccode_t  es_exccode,
    output logic                br_valid,
    output logic                br_taken,
    output exec_pkg::word_t     br_target,
    output logic                br_predict_ok,
    output logic                fwd_valid,
    output exec_pkg::reg_addr_t fwd_dest,
    output exec_pkg::word_t     fwd_result
);
    import exec_pkg::*;

    logic es_valid;
    logic es_first;
    logic es_ready_go;

    // latched instruction
    word_t     pc_r;
    word_t     rs_value_r;
    word_t     rt_value_r;
    word_t     imm_r;
    logic [4:0] shamt_r;
    alu_op_t   alu_op_r;
    logic      src2_is_imm_r;
    logic      trap_ov_r;
    hilo_op_t  hi_lo_op_r;
    res_sel_t  res_sel_r;
    br_op_t    br_op_r;
    word_t     branch_target_r;
    word_t     jump_target_r;
    logic      predict_taken_r;
    word_t     predict_target_r;
    reg_addr_t dest_r;
    logic      rf_we_r;
    logic      ex_r;
    exccode_t  exccode_r;

    word_t alu_src2;
    word_t alu_result;
    logic  alu_ov;
    logic  hilo_write;
    logic  hilo_start;
    logic  hi_lo_ready;
    word_t hi_lo_result;
    word_t final_result;

    assign es_ready_go = es_valid && (hi_lo_op_r == hilo_none || hi_lo_ready);
    assign es_allowin  = !es_valid || (es_ready_go && pms_allowin);
    assign es_to_valid = es_ready_go;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            es_valid <= 1'b0;
            es_first <= 1'b0;
        end else begin
            if (es_allowin) begin
                es_valid <= ds_valid;
            end
            // high only in the first cycle an instruction is held
            es_first <= es_allowin && ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_valid && es_allowin) begin
            pc_r             <= ds_pc;
            rs_value_r       <= ds_rs_value;
            rt_value_r       <= ds_rt_value;
            imm_r            <= ds_imm;
            shamt_r          <= ds_shamt;
            alu_op_r         <= ds_alu_op;
            src2_is_imm_r    <= ds_src2_is_imm;
            trap_ov_r        <= ds_trap_ov;
            hi_lo_op_r       <= ds_hi_lo_op;
            res_sel_r        <= ds_res_sel;
            br_op_r          <= ds_br_op;
            branch_target_r  <= ds_branch_target;
            jump_target_r    <= ds_jump_target;
            predict_taken_r  <= ds_predict_taken;
            predict_target_r <= ds_predict_target;
            dest_r           <= ds_dest;
            rf_we_r          <= ds_rf_we;
            ex_r             <= ds_ex;
            exccode_r        <= ds_exccode;
        end
    end

    assign alu_src2 = src2_is_imm_r ? imm_r : rt_value_r;

    alu u_alu (
        .alu_op  (alu_op_r),
        .src1    (rs_value_r),
        .src2    (alu_src2),
        .shamt   (shamt_r),
        .trap_ov (trap_ov_r),
        .result  (alu_result),
        .ov      (alu_ov)
    );

    // ops that change HI or LO
    assign hilo_write = (hi_lo_op_r == hilo_mult) || (hi_lo_op_r == hilo_multu)
                     || (hi_lo_op_r == hilo_div)  || (hi_lo_op_r == hilo_divu)
                     || (hi_lo_op_r == hilo_mthi) || (hi_lo_op_r == hilo_mtlo);

    // a faulting instruction must leave HI and LO alone
    assign hilo_start = es_valid && es_first && hilo_write && !es_ex;

    reg_hilo u_reg_hilo (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .start        (hilo_start),
        .hi_lo_op     (hi_lo_op_r),
        .src1         (rs_value_r),
        .src2         (rt_value_r),
        .hi_lo_ready  (hi_lo_ready),
        .hi_lo_result (hi_lo_result)
    );

    branch_control u_branch_control (
        .es_valid       (es_valid),
        .br_op          (br_op_r),
        .rs_value       (rs_value_r),
        .rt_value       (rt_value_r),
        .branch_target  (branch_target_r),
        .jump_target    (jump_target_r),
        .predict_taken  (predict_taken_r),
        .predict_target (predict_target_r),
        .br_taken       (br_taken),
        .br_target      (br_target),
        .predict_ok     (br_predict_ok)
    );

    assign br_valid = es_valid;

    always_comb begin
        case (res_sel_r)
            res_hilo: final_result = hi_lo_result;
            res_rt:   final_result = rt_value_r;
            default:  final_result = alu_result;
        endcase
    end

    // upstream exception wins over overflow
    assign es_ex = es_valid && (ex_r || alu_ov);
    always_comb begin
        if (!es_valid) begin
            es_exccode = '0;
        end else if (ex_r) begin
            es_exccode = exccode_r;
        end else if (alu_ov) begin
            es_exccode = `EXCCODE_OV;
        end else begin
            es_exccode = '0;
        end
    end

    assign es_pc     = pc_r;
    assign es_result = final_result;
    assign es_dest   = dest_r;
    assign es_rf_we  = es_valid && rf_we_r && !es_ex;

    // dest visible while held, result usable once ready to go
    assign fwd_valid  = es_to_valid;
    assign fwd_dest   = es_rf_we ? dest_r : '0;
    assign fwd_result = final_result;

endmodule

// ==== hw/branch_control.sv ====
`timescale 1ns/1ps
`include "exec_params.svh"

module branch_control (
    input  logic             es_valid,
    input  exec_pkg::br_op_t br_op,
    input  exec_pkg::word_t  rs_value,
    input  exec_pkg::word_t  rt_value,
    input  exec_pkg::word_t  branch_target,
    input  exec_pkg::word_t  jump_target,
    input  logic             predict_taken,
    input  exec_pkg::word_t  predict_target,
    output logic             br_taken,
    output exec_pkg::word_t  br_target,
    output logic             predict_ok
);
    import exec_pkg::*;

    logic rs_neg;
    logic rs_zero;
    logic rs_eq_rt;
    logic cond;

    assign rs_neg   = rs_value[`WORD_W-1];
    assign rs_zero  = (rs_value == '0);
    assign rs_eq_rt = (rs_value == rt_value);

    always_comb begin
        case (br_op)
            br_beq:  cond = rs_eq_rt;
            br_bne:  cond = !rs_eq_rt;
            br_bgez: cond = !rs_neg;
            br_bgtz: cond = !rs_neg && !rs_zero;
            br_blez: cond = rs_neg || rs_zero;
            br_bltz: cond = rs_neg;
            br_j:    cond = 1'b1;
            br_jr:   cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    // non-branches resolve as not taken
    assign br_taken = es_valid && cond;

    always_comb begin
        case (br_op)
            br_jr:   br_target = rs_value;
            br_j:    br_target = jump_target;
            default: br_target = branch_target;
        endcase
    end

    // target only matters on a taken outcome
    assign predict_ok = (br_taken == predict_taken) && (!br_taken || br_target == predict_target);

endmodule

// ==== hw/reg_hilo.sv ====
`timescale 1ns/1ps
`include "exec_params.svh"

module reg_hilo (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               start,
    input  exec_pkg::hilo_op_t hi_lo_op,
    input  exec_pkg::word_t    src1,
    input  exec_pkg::word_t    src2,
    output logic               hi_lo_ready,
    output exec_pkg::word_t    hi_lo_result
);
    import exec_pkg::*;

    localparam int W     = `WORD_W;
    localparam int CNT_W = $clog2(`DIV_STEPS);

    muldiv_state_t    state;
    logic [CNT_W-1:0] step;
    word_t            hi;
    word_t            lo;
    word_t            operand;
    logic [2*W-1:0]   acc;
    logic [2*W-1:0]   acc_next;
    logic [2*W-1:0]   product;
    logic             neg_lo;
    logic             neg_hi;
    logic             is_signed;
    logic             is_mul_op;
    logic             is_div_op;
    logic             div_zero;
    logic             last_step;
    word_t            src1_mag;
    word_t            src2_mag;
    logic [W:0]       mul_sum;
    logic [W:0]       rem_shift;
    logic [W:0]       rem_next;
    logic             div_ge;
    word_t            quo_fix;
    word_t            rem_fix;

    assign is_mul_op = (hi_lo_op == hilo_mult) || (hi_lo_op == hilo_multu);
    assign is_div_op = (hi_lo_op == hilo_div) || (hi_lo_op == hilo_divu);
    assign is_signed = (hi_lo_op == hilo_mult) || (hi_lo_op == hilo_div);
    assign div_zero  = (src2 == '0);
    assign last_step = (step == CNT_W'(`DIV_STEPS - 1));

    assign src1_mag = (is_signed && src1[W-1]) ? -src1 : src1;
    assign src2_mag = (is_signed && src2[W-1]) ? -src2 : src2;

    // low until the last iteration of a running op
    assign hi_lo_ready = (state == md_idle) ? !(start && (is_mul_op || (is_div_op && !div_zero)))
                                            : last_step;

    assign hi_lo_result = (hi_lo_op == hilo_mfhi) ? hi : lo;

    // shift-add step, multiplier bits leave at the bottom of acc
    assign mul_sum = {1'b0, acc[2*W-1:W]} + (acc[0] ? {1'b0, operand} : {(W+1){1'b0}});

    // restoring step, acc holds {remainder, dividend and quotient bits}
    assign rem_shift = acc[2*W-1:W-1];
    assign div_ge    = rem_shift >= {1'b0, operand};
    assign rem_next  = div_ge ? rem_shift - {1'b0, operand} : rem_shift;

    assign acc_next = (state == md_div_run) ? {rem_next[W-1:0], acc[W-2:0], div_ge}
                                            : {mul_sum, acc[W-1:1]};

    // sign fix on the final value
    assign product = neg_lo ? -acc_next : acc_next;
    assign quo_fix = neg_lo ? -acc_next[W-1:0] : acc_next[W-1:0];
    assign rem_fix = neg_hi ? -acc_next[2*W-1:W] : acc_next[2*W-1:W];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= md_idle;
            step  <= '0;
            hi    <= '0;
            lo    <= '0;
        end else if (flush) begin
            state <= md_idle;
            step  <= '0;
        end else begin
            case (state)
                md_idle: begin
                    step <= '0;
                    if (start) begin
                        if (hi_lo_op == hilo_mthi) begin
                            hi <= src1;
                        end else if (hi_lo_op == hilo_mtlo) begin
                            lo <= src1;
                        end else if (is_mul_op) begin
                            state <= md_mul_run;
                        end else if (is_div_op && !div_zero) begin
                            state <= md_div_run;
                        end
                    end
                end
                md_mul_run: begin
                    step <= step + 1'b1;
                    if (last_step) begin
                        state    <= md_idle;
                        {hi, lo} <= product;
                    end
                end
                md_div_run: begin
                    step <= step + 1'b1;
                    if (last_step) begin
                        state <= md_idle;
                        hi    <= rem_fix;
                        lo    <= quo_fix;
                    end
                end
                default: begin
                    state <= md_idle;
                end
            endcase
        end
    end

    // operand magnitudes and result signs captured at start
    always_ff @(posedge clk) begin
        if (state == md_idle && start) begin
            operand <= is_div_op ? src2_mag : src1_mag;
            acc     <= {{W{1'b0}}, (is_div_op ? src1_mag : src2_mag)};
            neg_lo  <= is_signed && (src1[W-1] ^ src2[W-1]);
            neg_hi  <= is_signed && src1[W-1];
        end else if (state != md_idle) begin
            acc <= acc_next;
        end
    end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`include "exec_params.svh"

module alu (
    input  exec_pkg::alu_op_t alu_op,
    input  exec_pkg::word_t   src1,
    input  exec_pkg::word_t   src2,
    input  logic [4:0]        shamt,
    input  logic              trap_ov,
    output exec_pkg::word_t   result,
    output logic              ov
);
    import exec_pkg::*;

    localparam int MSB = `WORD_W - 1;

    word_t sum;
    word_t diff;
    logic  add_ov;
    logic  sub_ov;
    logic  lt_signed;
    logic  lt_unsigned;

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    // same-sign operands, result sign flipped
    assign add_ov = (src1[MSB] == src2[MSB]) && (sum[MSB] != src1[MSB]);
    // opposite-sign operands, result sign differs from src1
    assign sub_ov = (src1[MSB] != src2[MSB]) && (diff[MSB] != src1[MSB]);

    // sign of the difference, corrected when it wrapped
    assign lt_signed   = diff[MSB] ^ sub_ov;
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (alu_op)
            alu_add: begin
                result = sum;
            end
            alu_sub: begin
                result = diff;
            end
            alu_slt: begin
                result = {{MSB{1'b0}}, lt_signed};
            end
            alu_sltu: begin
                result = {{MSB{1'b0}}, lt_unsigned};
            end
            alu_and: begin
                result = src1 & src2;
            end
            alu_or: begin
                result = src1 | src2;
            end
            alu_xor: begin
                result = src1 ^ src2;
            end
            alu_nor: begin
                result = ~(src1 | src2);
            end
            // shifts act on the rt operand
            alu_sll: begin
                result = src2 << shamt;
            end
            alu_srl: begin
                result = src2 >> shamt;
            end
            alu_sra: begin
                result = word_t'($signed(src2) >>> shamt);
            end
            alu_lui: begin
                result = src2 << 16;
            end
            default: begin
                result = sum;
            end
        endcase
    end

    // addu and subu come with trap_ov clear
    assign ov = trap_ov && ((alu_op == alu_add && add_ov) || (alu_op == alu_sub && sub_ov));

endmodule

// ==== hw/exec_pkg.sv ====
`include "exec_params.svh"

package exec_pkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`EXCCODE_W-1:0] exccode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_t;

    typedef enum logic [3:0] {
        hilo_none,
        hilo_mult,
        hilo_multu,
        hilo_div,
        hilo_divu,
        hilo_mthi,
        hilo_mtlo,
        hilo_mfhi,
        hilo_mflo
    } hilo_op_t;

    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_bgez,
        br_bgtz,
        br_blez,
        br_bltz,
        br_j,
        br_jr
    } br_op_t;

    // source of the value written back
    typedef enum logic [1:0] {
        res_alu,
        res_hilo,
        res_rt
    } res_sel_t;

    typedef enum logic [1:0] {
        md_idle,
        md_mul_run,
        md_div_run
    } muldiv_state_t;

endpackage

// ==== hw/exec_params.svh ====
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// datapath word width
`define WORD_W 32

// register number and exception code widths
`define REG_ADDR_W 5
`define EXCCODE_W 5

// arithmetic overflow
`define EXCCODE_OV 5'h0c

// one step per operand bit for mult and div
`define DIV_STEPS 32

`endif
